// ==== design/fpw_pkg.sv ====
package fpw_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int unsigned FLEN          = 32; // FP32 operands only
    localparam int unsigned TRANS_ID_BITS = 3;  // Tag width from issue

    typedef logic [FLEN-1:0]          fp_word_t;
    typedef logic [TRANS_ID_BITS-1:0] fp_tag_t;

    // ----------------------------------------------------------
    // Opcodes
    // ----------------------------------------------------------
    // Opcode as it arrives from the issue port
    typedef enum logic [1:0] {
        FSGNJ,   // Sign injection, variant in rm
        FMINMAX, // Min or max, variant in rm[0]
        FCMP,    // Compare, variant in rm
        FMV      // Register move
    } fp_opcode_e;

    // Internal op seen by the two lanes
    typedef enum logic [3:0] {
        OP_SGNJ,
        OP_SGNJN,
        OP_SGNJX,
        OP_MOVE,  // Raw passthrough of operand a
        OP_MIN,
        OP_MAX,
        OP_LE,
        OP_LT,
        OP_EQ
    } fp_lane_op_e;

    // ----------------------------------------------------------
    // Request and result bundles
    // ----------------------------------------------------------
    typedef struct packed {
        fp_opcode_e opcode;
        logic [2:0] rm;        // Variant select, MSB is ignored
        fp_word_t   operand_a;
        fp_word_t   operand_b;
        fp_tag_t    tag;
    } fp_issue_t;

    typedef struct packed {
        fp_lane_op_e op;
        fp_word_t    operand_a;
        fp_word_t    operand_b;
        fp_tag_t     tag;
    } fp_req_t;

    typedef struct packed {
        fp_word_t result;
        fp_tag_t  tag;   // Same tag as the request
    } fp_resp_t;

endpackage

// ==== design/fp_op_decoder.sv ====
`timescale 1ns/1ps

module fp_op_decoder (
    input  fpw_pkg::fp_issue_t issue_i,
    output fpw_pkg::fp_req_t   req_o
);
    import fpw_pkg::*;

    logic [1:0] rm_low; // Only low rm bits carry the variant

    assign rm_low = issue_i.rm[1:0];

    // ----------------------------------------------------------
    // Opcode and rm to lane op
    // ----------------------------------------------------------
    always_comb begin : input_translation
        // Operands and tag pass unchanged
        req_o.operand_a = issue_i.operand_a;
        req_o.operand_b = issue_i.operand_b;
        req_o.tag       = issue_i.tag;
        req_o.op        = OP_MOVE; // Safe default

        case (issue_i.opcode)
            FSGNJ: begin
                case (rm_low)
                    2'd0:    req_o.op = OP_SGNJ;
                    2'd1:    req_o.op = OP_SGNJN;
                    2'd2:    req_o.op = OP_SGNJX;
                    default: req_o.op = OP_MOVE; // rm 3 is raw passthrough
                endcase
            end
            FMINMAX: req_o.op = rm_low[0] ? OP_MAX : OP_MIN;
            FCMP: begin
                case (rm_low)
                    2'd0:    req_o.op = OP_LE;
                    2'd1:    req_o.op = OP_LT;
                    default: req_o.op = OP_EQ; // 2 and 3 both compare equal
                endcase
            end
            FMV:     req_o.op = OP_MOVE;
            default: req_o.op = OP_MOVE;
        endcase

        // Issue side must never present an undriven opcode
        assert final (!$isunknown(issue_i.opcode))
            else $error("fp_op_decoder: opcode unknown");
    end

endmodule

// ==== design/fp_issue_buffer.sv ====
`timescale 1ns/1ps

module fp_issue_buffer (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             valid_i,
    output logic             ready_o,
    input  fpw_pkg::fp_req_t req_i,
    input  logic             unit_ready_i,
    output logic             unit_valid_o,
    output fpw_pkg::fp_req_t req_o
);
    import fpw_pkg::*;

    typedef enum logic {READY, STALL} state_e;

    state_e  state_q, state_d;
    logic    hold_inputs; // Capture request into hold register
    logic    use_hold;    // Drive unit from hold register
    fp_req_t hold_q;

    // ----------------------------------------------------------
    // Protocol inversion, unit valid depends on unit ready
    // ----------------------------------------------------------
    always_comb begin : p_input_fsm
        ready_o      = 1'b0;
        unit_valid_o = 1'b0;
        hold_inputs  = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        case (state_q)
            READY: begin
                ready_o      = 1'b1;    // Look ready to issue
                unit_valid_o = valid_i; // Pass straight through
                if (valid_i && !unit_ready_i) begin
                    ready_o     = 1'b0; // Unit busy, keep request upstream
                    hold_inputs = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                unit_valid_o = 1'b1; // Held request pending
                use_hold     = 1'b1;
                if (unit_ready_i) begin
                    ready_o = 1'b1;  // Token back to issue
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        // Flush drops the held request and takes nothing new this cycle
        if (flush_i) begin
            ready_o      = 1'b0;
            unit_valid_o = 1'b0;
            hold_inputs  = 1'b0;
            state_d      = READY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin : p_hold_reg
        if (hold_inputs) begin
            hold_q <= req_i;
        end
    end

    assign req_o = use_hold ? hold_q : req_i; // Output mux

    // Requester keeps the stalled request until ready_o rises
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == STALL) |-> valid_i && (req_i == hold_q))
        else $error("fp_issue_buffer: upstream request changed while held in STALL");

endmodule

// ==== design/fp_sgnj_lane.sv ====
`timescale 1ns/1ps

module fp_sgnj_lane (
    input  fpw_pkg::fp_req_t req_i,
    output fpw_pkg::fp_word_t result_o
);
    import fpw_pkg::*;

    logic            sign_a;
    logic            sign_b;
    logic [FLEN-2:0] mag_a; // Exponent and mantissa of a

    assign sign_a = req_i.operand_a[FLEN-1];
    assign sign_b = req_i.operand_b[FLEN-1];
    assign mag_a  = req_i.operand_a[FLEN-2:0];

    // ----------------------------------------------------------
    // Sign injection, magnitude always from a
    // ----------------------------------------------------------
    always_comb begin : p_sgnj
        case (req_i.op)
            OP_SGNJ:  result_o = {sign_b, mag_a};
            OP_SGNJN: result_o = {~sign_b, mag_a};
            OP_SGNJX: result_o = {sign_a ^ sign_b, mag_a};
            OP_MOVE:  result_o = req_i.operand_a; // Bits unchanged
            // Ops of the compare lane, result not selected
            default:  result_o = req_i.operand_a;
        endcase
    end

endmodule

// ==== design/fp_cmp_lane.sv ====
`timescale 1ns/1ps

module fp_cmp_lane (
    input  fpw_pkg::fp_req_t req_i,
    output fpw_pkg::fp_word_t result_o
);
    import fpw_pkg::*;

    logic            sign_a, sign_b;
    logic [FLEN-2:0] mag_a, mag_b;
    logic            a_lt_b; // Strict total order
    logic            a_eq_b; // Identical patterns
    logic            a_le_b;

    assign sign_a = req_i.operand_a[FLEN-1];
    assign sign_b = req_i.operand_b[FLEN-1];
    assign mag_a  = req_i.operand_a[FLEN-2:0];
    assign mag_b  = req_i.operand_b[FLEN-2:0];

    // ----------------------------------------------------------
    // Sign-magnitude ordering, -0 below +0
    // ----------------------------------------------------------
    always_comb begin : p_order
        if (sign_a != sign_b) begin
            a_lt_b = sign_a;          // Negative sorts first
        end else if (!sign_a) begin
            a_lt_b = mag_a < mag_b;
        end else begin
            a_lt_b = mag_a > mag_b;   // Both negative, reversed
        end
    end

    assign a_eq_b = (req_i.operand_a == req_i.operand_b);
    assign a_le_b = a_lt_b | a_eq_b;

    always_comb begin : p_result
        case (req_i.op)
            OP_MIN:  result_o = a_le_b ? req_i.operand_a : req_i.operand_b; // a on tie
            OP_MAX:  result_o = a_lt_b ? req_i.operand_b : req_i.operand_a; // a on tie
            OP_LE:   result_o = {{(FLEN-1){1'b0}}, a_le_b};
            OP_LT:   result_o = {{(FLEN-1){1'b0}}, a_lt_b};
            OP_EQ:   result_o = {{(FLEN-1){1'b0}}, a_eq_b};
            default: result_o = req_i.operand_a; // Sign lane ops
        endcase
    end

endmodule

// ==== design/fp_result_stage.sv ====
`timescale 1ns/1ps

module fp_result_stage (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 unit_valid_i,
    output logic                 unit_ready_o,
    input  fpw_pkg::fp_lane_op_e op_i,
    input  fpw_pkg::fp_tag_t     tag_i,
    input  fpw_pkg::fp_word_t    sgnj_result_i,
    input  fpw_pkg::fp_word_t    cmp_result_i,
    input  logic                 result_ready_i,
    output fpw_pkg::fp_resp_t    resp_o,
    output logic                 result_valid_o
);
    import fpw_pkg::*;

    logic     valid_q;  // Register holds an untaken result
    logic     load;     // Unit handshake this cycle
    fp_resp_t resp_d, resp_q;

    // ----------------------------------------------------------
    // Lane select and handshake
    // ----------------------------------------------------------
    always_comb begin : p_select
        resp_d.tag = tag_i;
        if (op_i inside {OP_SGNJ, OP_SGNJN, OP_SGNJX, OP_MOVE}) begin
            resp_d.result = sgnj_result_i;
        end else begin
            resp_d.result = cmp_result_i;
        end
    end

    assign unit_ready_o = !valid_q || result_ready_i; // Room once current one leaves
    assign load         = unit_valid_i && unit_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;   // Drop in-flight result
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (result_ready_i) begin
            valid_q <= 1'b0;   // Taken, nothing new
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (load) begin
            resp_q <= resp_d;
        end
    end

    assign resp_o         = resp_q;
    assign result_valid_o = valid_q;

    // Writeback stall must not disturb the presented result
    a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_o && !result_ready_i && !flush_i
        |=> result_valid_o && $stable(resp_o))
        else $error("fp_result_stage: result changed under back-pressure");

endmodule

// ==== design/fp_wrap_top.sv ====
`timescale 1ns/1ps

module fp_wrap_top (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  logic               valid_i,
    output logic               ready_o,
    input  fpw_pkg::fp_issue_t issue_i,
    input  logic               result_ready_i,
    output logic               result_valid_o,
    output fpw_pkg::fp_resp_t  resp_o
);
    import fpw_pkg::*;

    fp_req_t  dec_req;     // Decoded, before the hold buffer
    fp_req_t  unit_req;    // Request seen by the lanes
    logic     unit_valid;
    logic     unit_ready;
    fp_word_t sgnj_result;
    fp_word_t cmp_result;

    // ----------------------------------------------------------
    // Decode and protocol inversion
    // ----------------------------------------------------------
    fp_op_decoder u_decoder (
        .issue_i ( issue_i ),
        .req_o   ( dec_req )
    );

    fp_issue_buffer u_issue_buffer (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .flush_i      ( flush_i    ),
        .valid_i      ( valid_i    ),
        .ready_o      ( ready_o    ),
        .req_i        ( dec_req    ),
        .unit_ready_i ( unit_ready ),
        .unit_valid_o ( unit_valid ),
        .req_o        ( unit_req   )
    );

    // ----------------------------------------------------------
    // Lanes and result register
    // ----------------------------------------------------------
    fp_sgnj_lane u_sgnj_lane (
        .req_i    ( unit_req    ),
        .result_o ( sgnj_result )
    );

    fp_cmp_lane u_cmp_lane (
        .req_i    ( unit_req   ),
        .result_o ( cmp_result )
    );

    fp_result_stage u_result_stage (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( flush_i        ),
        .unit_valid_i   ( unit_valid     ),
        .unit_ready_o   ( unit_ready     ),
        .op_i           ( unit_req.op    ),
        .tag_i          ( unit_req.tag   ),
        .sgnj_result_i  ( sgnj_result    ),
        .cmp_result_i   ( cmp_result     ),
        .result_ready_i ( result_ready_i ),
        .resp_o         ( resp_o         ),
        .result_valid_o ( result_valid_o )
    );

endmodule

// ==== bench/tb_fp_wrap.sv ====
`timescale 1ns/1ps

module tb_fp_wrap;
    import fpw_pkg::*;

    localparam int unsigned NUM_REQ        = 400;
    localparam int unsigned TIMEOUT_CYCLES = NUM_REQ * 8 + 200; // About 8 cycles per request
    localparam int unsigned SEED           = 10648;
    localparam fp_word_t    SIGN_MASK      = {1'b1, {(FLEN-1){1'b0}}};

    logic      clk_i;
    logic      rst_ni;
    logic      flush_i;
    logic      valid_i;
    logic      ready_o;
    fp_issue_t issue_i;
    logic      result_ready_i;
    logic      result_valid_o;
    fp_resp_t  resp_o;

    fp_resp_t    exp_q[$];   // Expected results in acceptance order
    fp_issue_t   req_q[$];   // Matching requests, for error context
    int unsigned n_accepted;
    int unsigned n_checked;
    int unsigned n_flushes;
    int unsigned cycle_count;
    logic        issue_fire; // Handshake seen at the last falling edge
    logic        driving;    // Random stimulus running

    fp_wrap_top u_dut (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( flush_i        ),
        .valid_i        ( valid_i        ),
        .ready_o        ( ready_o        ),
        .issue_i        ( issue_i        ),
        .result_ready_i ( result_ready_i ),
        .result_valid_o ( result_valid_o ),
        .resp_o         ( resp_o         )
    );

    always #2 clk_i = ~clk_i; // 4 ns period

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic fp_resp_t expected_resp(fp_issue_t req);
        fp_resp_t resp;
        fp_word_t a;
        fp_word_t b;
        fp_word_t key_a;
        fp_word_t key_b;
        logic     lt;
        logic     eq;
        a     = req.operand_a;
        b     = req.operand_b;
        key_a = a[FLEN-1] ? ~a : (a | SIGN_MASK); // Unsigned key in total order
        key_b = b[FLEN-1] ? ~b : (b | SIGN_MASK);
        lt    = key_a < key_b;
        eq    = key_a == key_b;                   // Key map is one to one
        resp.tag = req.tag;
        case (req.opcode)
            FSGNJ: begin
                case (req.rm[1:0])
                    2'd0:    resp.result = {b[FLEN-1], a[FLEN-2:0]};
                    2'd1:    resp.result = {~b[FLEN-1], a[FLEN-2:0]};
                    2'd2:    resp.result = {a[FLEN-1] ^ b[FLEN-1], a[FLEN-2:0]};
                    default: resp.result = a;     // Passthrough
                endcase
            end
            FMINMAX: begin
                if (req.rm[0]) resp.result = lt ? b : a;        // Max, a on tie
                else           resp.result = (lt || eq) ? a : b; // Min, a on tie
            end
            FCMP: begin
                case (req.rm[1:0])
                    2'd0:    resp.result = fp_word_t'(lt || eq);
                    2'd1:    resp.result = fp_word_t'(lt);
                    default: resp.result = fp_word_t'(eq);
                endcase
            end
            default: resp.result = a;             // FMV
        endcase
        return resp;
    endfunction

    // Random opcode and rm, operands drawn from a few corner classes
    function automatic fp_issue_t random_issue();
        fp_issue_t   req;
        logic [31:0] r;
        fp_word_t    a;
        fp_word_t    b;
        r = $urandom;
        a = $urandom;
        case (r[10:8])
            3'd0: b = a;                              // Equal pair
            3'd1: b = a ^ SIGN_MASK;                  // Sign flipped
            3'd2: begin
                a = {r[11], {(FLEN-1){1'b0}}};        // +0 against -0
                b = {~r[11], {(FLEN-1){1'b0}}};
            end
            3'd3: begin
                a = {r[11], {(FLEN-1){1'b0}}};        // Zero against random
                b = $urandom;
            end
            3'd4: b = {a[FLEN-1], a[FLEN-2:0] + {{(FLEN-5){1'b0}}, r[15:12]}}; // Close magnitude
            default: b = $urandom;
        endcase
        req.opcode    = fp_opcode_e'(r[1:0]);
        req.rm        = r[4:2];
        req.tag       = r[7:5];
        req.operand_a = a;
        req.operand_b = b;
        return req;
    endfunction

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_data(fp_word_t got, fp_word_t exp, fp_issue_t req);
        if (got !== exp) begin
            $display("ERR %0t: result %h expected %h (%s rm %0d a %h b %h)", $time, got, exp,
                     req.opcode.name(), req.rm, req.operand_a, req.operand_b);
            stop_with_failure();
        end
    endtask

    task automatic check_tag(fp_tag_t got, fp_tag_t exp);
        if (got !== exp) begin
            $display("ERR %0t: tag %0d expected %0d", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_ready(logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %0t: ready_o %b expected %b under back-pressure", $time, got, exp);
            stop_with_failure();
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus, driven on the rising edge
    // ----------------------------------------------------------
    always @(posedge clk_i) begin : drive_inputs
        if (driving) begin
            result_ready_i <= ($urandom % 4) != 0;
            flush_i        <= !flush_i && (n_accepted < NUM_REQ) && (($urandom % 50) == 0);
            if (!valid_i || issue_fire) begin     // Request held until accepted
                if ((n_accepted < NUM_REQ) && (($urandom % 4) != 0)) begin
                    valid_i <= 1'b1;
                    issue_i <= random_issue();
                end else begin
                    valid_i <= 1'b0;
                end
            end
        end
    end

    // Sample mid cycle where everything is settled
    always @(negedge clk_i) begin : compare_results
        fp_resp_t  exp;
        fp_issue_t req;
        issue_fire = valid_i && ready_o;
        if (rst_ni) begin
            // Full result register with writeback stalled, request must wait
            if (valid_i && result_valid_o && !result_ready_i) begin
                check_ready(ready_o, 1'b0);
            end
            if (flush_i) begin
                exp_q.delete();                   // Pending results are dropped
                req_q.delete();
                n_flushes++;
            end else begin
                if (result_valid_o && result_ready_i) begin
                    if (exp_q.size() == 0) begin
                        $display("Result with tag %0d taken but no request is pending",
                                 resp_o.tag);
                        stop_with_failure();
                    end else begin
                        exp = exp_q.pop_front();
                        req = req_q.pop_front();
                        check_data(resp_o.result, exp.result, req);
                        check_tag(resp_o.tag, exp.tag);
                        n_checked++;
                    end
                end
                if (issue_fire) begin
                    exp_q.push_back(expected_resp(issue_i));
                    req_q.push_back(issue_i);
                    n_accepted++;
                end
            end
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d requests accepted",
                     cycle_count, n_accepted, NUM_REQ);
            stop_with_failure();
        end
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin : run_test
        void'($urandom(SEED));
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        valid_i        = 1'b0;
        issue_i        = '0;
        result_ready_i = 1'b0;
        issue_fire     = 1'b0;
        driving        = 1'b0;
        n_accepted     = 0;
        n_checked      = 0;
        n_flushes      = 0;
        cycle_count    = 0;

        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        if (result_valid_o !== 1'b0 || ready_o !== 1'b1) begin
            $display("After reset result_valid_o is not low or ready_o is not high");
            stop_with_failure();
        end
        driving = 1'b1;

        // All requests accepted and every surviving result taken
        while (!(n_accepted == NUM_REQ && exp_q.size() == 0)) @(posedge clk_i);
        @(negedge clk_i);
        driving = 1'b0;
        @(posedge clk_i);
        result_ready_i <= 1'b1;
        repeat (10) @(posedge clk_i);             // Any stray result shows up here

        @(negedge clk_i);
        if (exp_q.size() != 0 || result_valid_o) begin
            $display("Run ended with %0d results pending", exp_q.size());
            stop_with_failure();
        end else begin
            $display("Checked %0d results, %0d flushes", n_checked, n_flushes);
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== project.f ====
design/fpw_pkg.sv
design/fp_op_decoder.sv
design/fp_issue_buffer.sv
design/fp_sgnj_lane.sv
design/fp_cmp_lane.sv
design/fp_result_stage.sv
design/fp_wrap_top.sv
bench/tb_fp_wrap.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fp_wrap
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
